//--- filelist.f
+incdir+rtl
rtl/adpcma_pkg.sv
rtl/adpcma_dec_if.sv
rtl/adpcma_seq.sv
rtl/adpcma_decoder.sv
rtl/adpcma_mix.sv
rtl/adpcma_top.sv
verif/adpcma_clkgen.sv
verif/adpcma_tb.sv

//--- rtl/adpcma_dec_if.sv
// Carries one slot's nibble from the sequencer into the ADPCM decoder, one slot per cen
`include "adpcma_params.svh"

interface adpcma_dec_if;

    logic [`ADPCMA_CHW-1:0] slot;   // Channel served this slot
    logic [3:0]             nibble; // Sign in bit 3
    logic                   valid;  // Channel is playing
    logic                   clr;    // First nibble after key-on

    // Sequencer side registers everything on cen
    modport seq (output slot, nibble, valid, clr);

    modport dec (input slot, nibble, valid, clr);

endinterface

//--- rtl/adpcma_decoder.sv
// Execute stage of the ADPCM-A engine, turns each slot's nibble into 16-bit PCM per channel
`include "adpcma_params.svh"

module adpcma_decoder
    import adpcma_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    adpcma_dec_if.dec                     dec,
    output logic [`ADPCMA_CHW-1:0]        dec_slot,
    output logic signed [`ADPCMA_PCMW-1:0] dec_pcm,   // Zero on idle slots
    output logic                          dec_valid
);

    logic signed [`ADPCMA_ACCW-1:0] acc [`ADPCMA_NCH];  // Per-channel decoder state
    logic [5:0]                     idx [`ADPCMA_NCH];
    logic signed [`ADPCMA_ACCW-1:0] acc_cur;
    logic signed [`ADPCMA_ACCW-1:0] acc_new;
    logic [5:0]                     idx_cur;
    logic [5:0]                     idx_new;
    logic [15:0]                    step;
    logic [15:0]                    diff;     // Tops out near 2910
    logic signed [`ADPCMA_DSW-1:0]  diff_s;
    logic signed [`ADPCMA_DSW-1:0]  sum;
    logic signed [6:0]              idx_sum;

    // Key-on restarts from zero state
    assign acc_cur = dec.clr ? '0 : acc[dec.slot];
    assign idx_cur = dec.clr ? '0 : idx[dec.slot];
    assign step    = step_table[idx_cur];

    always_comb begin
        diff = step >> 3;
        if (dec.nibble[0]) begin
            diff = diff + (step >> 2);
        end
        if (dec.nibble[1]) begin
            diff = diff + (step >> 1);
        end
        if (dec.nibble[2]) begin
            diff = diff + step;
        end
    end

    assign diff_s  = $signed({2'b00, diff});
    assign sum     = dec.nibble[3] ? acc_cur - diff_s : acc_cur + diff_s;
    assign acc_new = sat12(sum);

    // Step index moves by the table, held inside 0..48
    assign idx_sum = $signed({1'b0, idx_cur}) + index_adj[dec.nibble[2:0]];
    assign idx_new = (idx_sum < 0) ? 6'd0 :
                     (idx_sum > `ADPCMA_IDXMAX) ? 6'(`ADPCMA_IDXMAX) : idx_sum[5:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCMA_NCH; i++) begin
                acc[i] <= '0;
                idx[i] <= '0;
            end
            dec_slot  <= '0;
            dec_pcm   <= '0;
            dec_valid <= 1'b0;
        end else if (cen) begin
            dec_slot  <= dec.slot;  // Slot tag advances even when idle
            dec_valid <= dec.valid;
            if (dec.valid) begin
                acc[dec.slot] <= acc_new;
                idx[dec.slot] <= idx_new;
                dec_pcm       <= {acc_new, 4'b0000};  // Scale to 16 bits
            end else begin
                dec_pcm <= '0;
            end
        end
    end

    for (genvar i = 0; i < `ADPCMA_NCH; i++) begin : g_idx_chk
        a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
            idx[i] <= `ADPCMA_IDXMAX);
    end

endmodule

//--- rtl/adpcma_mix.sv
// Result stage of the ADPCM-A engine, applies level and pan then sums a stereo sample per round
`include "adpcma_params.svh"

module adpcma_mix
    import adpcma_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cen,
    input  logic [5:0]                     atl,       // Total level, 63 is loudest
    input  logic [`ADPCMA_CHW-1:0]         up_lracl,  // Channel written, 6 and 7 mean idle
    input  logic [7:0]                     lracl_in,  // L, R, unused, 5-bit level
    input  logic [`ADPCMA_CHW-1:0]         dec_slot,
    input  logic signed [`ADPCMA_PCMW-1:0] dec_pcm,
    input  logic                           dec_valid,
    output logic signed [`ADPCMA_PCMW-1:0] pcm_l,
    output logic signed [`ADPCMA_PCMW-1:0] pcm_r,
    output logic                           mix_valid  // One clock per round
);

    localparam logic [`ADPCMA_CHW-1:0] last_ch = `ADPCMA_NCH - 1;

    logic [1:0]                     pan [`ADPCMA_NCH];  // Left enable in bit 1
    logic [4:0]                     lvl [`ADPCMA_NCH];
    logic [6:0]                     att;
    logic [3:0]                     shift;
    logic signed [`ADPCMA_PCMW-1:0] gained;
    logic signed [`ADPCMA_PCMW-1:0] con_l;
    logic signed [`ADPCMA_PCMW-1:0] con_r;
    logic signed [`ADPCMA_MSW-1:0]  acc_l;
    logic signed [`ADPCMA_MSW-1:0]  acc_r;
    logic signed [`ADPCMA_MSW-1:0]  sum_l;
    logic signed [`ADPCMA_MSW-1:0]  sum_r;
    logic                           round_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCMA_NCH; i++) begin
                pan[i] <= '0;
                lvl[i] <= '0;
            end
        end else if (up_lracl < `ADPCMA_NCH) begin
            pan[up_lracl] <= lracl_in[7:6];
            lvl[up_lracl] <= lracl_in[4:0];
        end
    end

    // Attenuation in 6 dB steps
    assign att   = (7'd63 - atl) + (7'd31 - lvl[dec_slot]);
    assign shift = att[6:3];  // At most 11, under the 15 cap
    assign gained = dec_valid ? (dec_pcm >>> shift) : 16'sd0;

    assign con_l = pan[dec_slot][1] ? gained : 16'sd0;
    assign con_r = pan[dec_slot][0] ? gained : 16'sd0;
    assign sum_l = acc_l + con_l;
    assign sum_r = acc_r + con_r;

    assign round_end = dec_slot == last_ch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l     <= '0;
            acc_r     <= '0;
            pcm_l     <= '0;
            pcm_r     <= '0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= 1'b0;
            if (cen) begin
                if (round_end) begin
                    pcm_l     <= sat16(sum_l);
                    pcm_r     <= sat16(sum_r);
                    mix_valid <= 1'b1;
                    acc_l     <= '0;  // Slot 0 starts a fresh round
                    acc_r     <= '0;
                end else begin
                    acc_l <= sum_l;
                    acc_r <= sum_r;
                end
            end
        end
    end

    // Rounds are six slots apart
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mix_valid |=> !mix_valid);

endmodule

//--- rtl/adpcma_params.svh
// Sizes shared by the ADPCM-A engine RTL, pulled in with `include wherever a width is needed
`ifndef ADPCMA_PARAMS_SVH
`define ADPCMA_PARAMS_SVH

// Channels and slots per round
`define ADPCMA_NCH    6
`define ADPCMA_CHW    3

// ROM byte address and start/end register widths
`define ADPCMA_AW     20
`define ADPCMA_RW     16

// Decoder accumulator, its pre-saturation sum, and PCM out
`define ADPCMA_ACCW   12
`define ADPCMA_DSW    18
`define ADPCMA_PCMW   16

// Round sum before the final clamp
`define ADPCMA_MSW    20

// Step table length and top legal index
`define ADPCMA_STEPS  49
`define ADPCMA_IDXMAX 48

`endif

//--- rtl/adpcma_pkg.sv
// Shared ADPCM-A tables and clamp functions, imported by the decoder, the mixer and the testbench
`include "adpcma_params.svh"

package adpcma_pkg;

    // Standard ADPCM-A step sizes, indexed 0..48
    localparam logic [15:0] step_table [`ADPCMA_STEPS] = '{
        16'd16,   16'd17,   16'd19,   16'd21,   16'd23,   16'd25,   16'd28,
        16'd31,   16'd34,   16'd37,   16'd41,   16'd45,   16'd50,   16'd55,
        16'd60,   16'd66,   16'd73,   16'd80,   16'd88,   16'd97,   16'd107,
        16'd118,  16'd130,  16'd143,  16'd157,  16'd173,  16'd190,  16'd209,
        16'd230,  16'd253,  16'd279,  16'd307,  16'd337,  16'd371,  16'd408,
        16'd449,  16'd494,  16'd544,  16'd598,  16'd658,  16'd724,  16'd796,
        16'd876,  16'd963,  16'd1060, 16'd1166, 16'd1282, 16'd1411, 16'd1552
    };

    // Index change per magnitude bits 2:0 of a nibble
    localparam logic signed [4:0] index_adj [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

    // Clamp a decoder sum into the 12-bit accumulator range
    function automatic logic signed [`ADPCMA_ACCW-1:0] sat12(
        input logic signed [`ADPCMA_DSW-1:0] x
    );
        if (x > 18'sd2047) return 12'sd2047;
        if (x < -18'sd2048) return -12'sd2048;
        return x[`ADPCMA_ACCW-1:0];
    endfunction

    // Clamp a round sum into one 16-bit output sample
    function automatic logic signed [`ADPCMA_PCMW-1:0] sat16(
        input logic signed [`ADPCMA_MSW-1:0] x
    );
        if (x > 20'sd32767) return 16'sd32767;
        if (x < -20'sd32768) return -16'sd32768;
        return x[`ADPCMA_PCMW-1:0];
    endfunction

endpackage

//--- rtl/adpcma_seq.sv
// Decode stage of the ADPCM-A engine, steps the slot round, keys channels and reads sample ROM
`include "adpcma_params.svh"

module adpcma_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cen,        // Advances one slot
    input  logic                   up_start,
    input  logic                   up_end,
    input  logic [`ADPCMA_CHW-1:0] up_addr,    // Channel for start/end writes
    input  logic [`ADPCMA_RW-1:0]  addr_in,
    input  logic                   up_aon,
    input  logic [7:0]             aon_cmd,    // Bit 7 set means key-off
    input  logic [7:0]             datain,     // Combinational ROM data
    input  logic [`ADPCMA_NCH-1:0] clr_flags,
    output logic [`ADPCMA_AW-1:0]  rom_addr,
    output logic                   roe_n,
    output logic [`ADPCMA_NCH-1:0] flags,      // End reached per channel
    adpcma_dec_if.seq              dec
);

    localparam logic [`ADPCMA_CHW-1:0] last_ch = `ADPCMA_NCH - 1;

    logic [`ADPCMA_CHW-1:0] slot;
    logic                   last_slot;
    logic                   aon_pend;   // Command waiting for slot 0
    logic                   aon_off;
    logic [`ADPCMA_NCH-1:0] aon_mask;
    logic [`ADPCMA_NCH-1:0] key_on;
    logic [`ADPCMA_NCH-1:0] key_off;
    logic [`ADPCMA_RW-1:0]  start_r [`ADPCMA_NCH];
    logic [`ADPCMA_RW-1:0]  end_r   [`ADPCMA_NCH];
    logic [`ADPCMA_AW-1:0]  cnt     [`ADPCMA_NCH];  // Byte counters
    logic [`ADPCMA_NCH-1:0] nib_lo;     // Low nibble next
    logic [`ADPCMA_NCH-1:0] play;
    logic [`ADPCMA_NCH-1:0] first;      // Decoder must restart
    logic                   at_end;

    assign last_slot = slot == last_ch;

    // Key command lands as slot 0 begins
    assign key_on  = (aon_pend && last_slot && !aon_off) ? aon_mask : '0;
    assign key_off = (aon_pend && last_slot && aon_off) ? aon_mask : '0;

    assign rom_addr = cnt[slot];
    assign roe_n    = ~play[slot];
    assign at_end   = cnt[slot] == {end_r[slot], 4'hf};  // Last byte of the sample

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (cen) begin
            slot <= last_slot ? '0 : slot + 1'b1;
        end
    end

    // Newer command waits while the older one is applied
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aon_pend <= 1'b0;
            aon_off  <= 1'b0;
            aon_mask <= '0;
        end else if (up_aon) begin
            aon_pend <= 1'b1;
            aon_off  <= aon_cmd[7];
            aon_mask <= aon_cmd[5:0];
        end else if (cen && last_slot) begin
            aon_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (up_start && up_addr < `ADPCMA_NCH) begin
            start_r[up_addr] <= addr_in;
        end
        if (up_end && up_addr < `ADPCMA_NCH) begin
            end_r[up_addr] <= addr_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCMA_NCH; i++) begin
                cnt[i] <= '0;
            end
            nib_lo <= '0;
            play   <= '0;
            first  <= '0;
            flags  <= '0;
        end else begin
            flags <= flags & ~clr_flags;
            if (cen) begin
                if (play[slot]) begin
                    nib_lo[slot] <= ~nib_lo[slot];
                    first[slot]  <= 1'b0;
                    if (nib_lo[slot]) begin  // Byte fully used
                        cnt[slot] <= cnt[slot] + 1'b1;
                        if (at_end) begin
                            play[slot]  <= 1'b0;
                            flags[slot] <= 1'b1;  // Wins over a clear
                        end
                    end
                end
                // Key command overrides the slot update
                for (int i = 0; i < `ADPCMA_NCH; i++) begin
                    if (key_on[i]) begin
                        cnt[i]    <= {start_r[i], 4'b0000};
                        nib_lo[i] <= 1'b0;
                        first[i]  <= 1'b1;
                        play[i]   <= 1'b1;
                        flags[i]  <= 1'b0;
                    end else if (key_off[i]) begin
                        play[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec.slot   <= '0;
            dec.nibble <= '0;
            dec.valid  <= 1'b0;
            dec.clr    <= 1'b0;
        end else if (cen) begin
            dec.slot   <= slot;
            dec.nibble <= nib_lo[slot] ? datain[3:0] : datain[7:4];  // High first
            dec.valid  <= play[slot];
            dec.clr    <= first[slot];
        end
    end

    // A second key command must not overwrite one still waiting for slot 0
    a_aon_keep: assert property (@(posedge clk) disable iff (!rst_n)
        up_aon |-> !aon_pend || (cen && last_slot));

    for (genvar i = 0; i < `ADPCMA_NCH; i++) begin : g_flag_chk
        a_flag_stop: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(flags[i]) |-> $fell(play[i]));
    end

endmodule

//--- rtl/adpcma_top.sv
// Top level of the six-channel ADPCM-A engine, joins sequencer, decoder and mixer
`include "adpcma_params.svh"

module adpcma_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cen,       // One slot per strobe
    input  logic                           up_start,
    input  logic                           up_end,
    input  logic [`ADPCMA_CHW-1:0]         up_addr,
    input  logic [`ADPCMA_RW-1:0]          addr_in,
    input  logic                           up_aon,
    input  logic [7:0]                     aon_cmd,
    input  logic [`ADPCMA_CHW-1:0]         up_lracl,  // 6 or 7 when no write
    input  logic [7:0]                     lracl_in,
    input  logic [5:0]                     atl,
    input  logic [`ADPCMA_NCH-1:0]         clr_flags,
    output logic [`ADPCMA_AW-1:0]          rom_addr,
    output logic                           roe_n,
    input  logic [7:0]                     datain,
    output logic [`ADPCMA_NCH-1:0]         flags,
    output logic signed [`ADPCMA_PCMW-1:0] pcm_l,
    output logic signed [`ADPCMA_PCMW-1:0] pcm_r,
    output logic                           mix_valid
);

    logic [`ADPCMA_CHW-1:0]         dec_slot;
    logic signed [`ADPCMA_PCMW-1:0] dec_pcm;
    logic                           dec_valid;

    adpcma_dec_if nib_if ();

    // Decode, one ROM byte feeds two slots of the same channel
    adpcma_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .up_start  (up_start),
        .up_end    (up_end),
        .up_addr   (up_addr),
        .addr_in   (addr_in),
        .up_aon    (up_aon),
        .aon_cmd   (aon_cmd),
        .datain    (datain),
        .clr_flags (clr_flags),
        .rom_addr  (rom_addr),
        .roe_n     (roe_n),
        .flags     (flags),
        .dec       (nib_if.seq)
    );

    // Execute, one slot behind
    adpcma_decoder u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .dec       (nib_if.dec),
        .dec_slot  (dec_slot),
        .dec_pcm   (dec_pcm),
        .dec_valid (dec_valid)
    );

    // Result, two slots behind
    adpcma_mix u_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .atl       (atl),
        .up_lracl  (up_lracl),
        .lracl_in  (lracl_in),
        .dec_slot  (dec_slot),
        .dec_pcm   (dec_pcm),
        .dec_valid (dec_valid),
        .pcm_l     (pcm_l),
        .pcm_r     (pcm_r),
        .mix_valid (mix_valid)
    );

endmodule

//--- verif/adpcma_clkgen.sv
// Free-running 50 MHz testbench clock and a power-on reset held low for two cycles
module adpcma_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;  // Release off the edge
    end

endmodule

//--- verif/adpcma_tb.sv
// Self-checking testbench for the ADPCM-A engine, holds the sample ROM and a slot-accurate model
`include "adpcma_params.svh"

module adpcma_tb
    import adpcma_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic               clk;
    logic               rst_n;
    logic               cen;
    logic               up_start;
    logic               up_end;
    logic [2:0]         up_addr;
    logic [15:0]        addr_in;
    logic               up_aon;
    logic [7:0]         aon_cmd;
    logic [2:0]         up_lracl;   // 7 when idle
    logic [7:0]         lracl_in;
    logic [5:0]         atl;
    logic [5:0]         clr_flags;
    logic [19:0]        rom_addr;
    logic               roe_n;
    logic [7:0]         datain;
    logic [5:0]         flags;
    logic signed [15:0] pcm_l;
    logic signed [15:0] pcm_r;
    logic               mix_valid;

    logic [7:0]  rom [1 << 20];  // 1 MB sample ROM
    logic [37:0] exp_q [$];      // Flags, left, right per round
    string       test_name;
    int          rounds_seen;
    int          sat_rounds;     // Rounds clipped by the model

    // Model state, mirrors every register stage
    int          m_slot;
    bit          m_pend;
    bit          m_off;
    logic [5:0]  m_mask;
    logic [15:0] m_start [6];
    logic [15:0] m_end   [6];
    logic [19:0] m_cnt   [6];
    bit          m_lo    [6];
    bit          m_play  [6];
    bit          m_first [6];
    logic [5:0]  m_flags;
    int          i_slot;         // Nibble stage copy
    logic [3:0]  i_nib;
    bit          i_valid;
    bit          i_clr;
    int          m_acc [6];
    int          m_idx [6];
    int          d_slot;         // Decoder output copy
    int          d_pcm;
    bit          d_valid;
    logic [1:0]  m_pan [6];
    int          m_lvl [6];
    int          sum_l;
    int          sum_r;

    adpcma_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

    adpcma_top adpcma_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .up_start  (up_start),
        .up_end    (up_end),
        .up_addr   (up_addr),
        .addr_in   (addr_in),
        .up_aon    (up_aon),
        .aon_cmd   (aon_cmd),
        .up_lracl  (up_lracl),
        .lracl_in  (lracl_in),
        .atl       (atl),
        .clr_flags (clr_flags),
        .rom_addr  (rom_addr),
        .roe_n     (roe_n),
        .datain    (datain),
        .flags     (flags),
        .pcm_l     (pcm_l),
        .pcm_r     (pcm_r),
        .mix_valid (mix_valid)
    );

    assign datain = rom[rom_addr];  // Asynchronous ROM

    function automatic int clamp(int x, int lo, int hi);
        if (x < lo) return lo;
        if (x > hi) return hi;
        return x;
    endfunction

    // Index change for magnitude bits
    function automatic int index_step(logic [2:0] mag);
        case (mag)
            3'd4: return 2;
            3'd5: return 5;
            3'd6: return 7;
            3'd7: return 9;
            default: return -1;
        endcase
    endfunction

    function automatic int nib_diff(int s, logic [3:0] nib);
        int d;
        d = s / 8;
        if (nib[0]) d += s / 4;
        if (nib[1]) d += s / 2;
        if (nib[2]) d += s;
        return d;
    endfunction

    function automatic int scaled(int pcm, int lvl_v, int atl_v);
        int sh;
        sh = ((63 - atl_v) + (31 - lvl_v)) / 8;
        if (sh > 15) sh = 15;
        return pcm >>> sh;  // 6 dB per step
    endfunction

    // Expected round: flags, saturated left and right
    function automatic logic [37:0] round_result(int l, int r, logic [5:0] f);
        logic [15:0] sl;
        logic [15:0] sr;
        sl = 16'(clamp(l, -32768, 32767));
        sr = 16'(clamp(r, -32768, 32767));
        return {f, sl, sr};
    endfunction

    task automatic clear_model();
        m_slot  = 0;
        m_pend  = 0;
        m_off   = 0;
        m_mask  = '0;
        m_flags = '0;
        i_slot  = 0;
        i_nib   = '0;
        i_valid = 0;
        i_clr   = 0;
        d_slot  = 0;
        d_pcm   = 0;
        d_valid = 0;
        sum_l   = 0;
        sum_r   = 0;
        for (int ch = 0; ch < 6; ch++) begin
            m_cnt[ch]   = '0;
            m_lo[ch]    = 0;
            m_play[ch]  = 0;
            m_first[ch] = 0;
            m_acc[ch]   = 0;
            m_idx[ch]   = 0;
            m_pan[ch]   = '0;
            m_lvl[ch]   = 0;
        end
    endtask

    // Reference model, one slot per cen, stages updated back to front
    always @(posedge clk) begin
        int         c_l;
        int         c_r;
        int         s;
        int         a;
        int         x;
        bit         done;
        logic [7:0] byte_v;
        if (rst_n) begin
            done    = 0;
            m_flags = m_flags & ~clr_flags;
            if (cen) begin
                c_l = 0;  // Mix stage
                c_r = 0;
                if (d_valid) begin
                    s = scaled(d_pcm, m_lvl[d_slot], atl);
                    if (m_pan[d_slot][1]) c_l = s;
                    if (m_pan[d_slot][0]) c_r = s;
                end
                sum_l += c_l;
                sum_r += c_r;
                if (d_slot == 5) begin
                    done = 1;
                    if (sum_l != clamp(sum_l, -32768, 32767) ||
                        sum_r != clamp(sum_r, -32768, 32767)) begin
                        sat_rounds++;
                    end
                end
                d_slot  = i_slot;  // Decode stage
                d_valid = i_valid;
                d_pcm   = 0;
                if (i_valid) begin
                    a = i_clr ? 0 : m_acc[i_slot];
                    x = i_clr ? 0 : m_idx[i_slot];
                    s = nib_diff(step_table[x], i_nib);
                    a = clamp(i_nib[3] ? a - s : a + s, -2048, 2047);
                    m_acc[i_slot] = a;
                    m_idx[i_slot] = clamp(x + index_step(i_nib[2:0]), 0, 48);
                    d_pcm = a * 16;
                end
                byte_v  = rom[m_cnt[m_slot]];  // Sequencer stage
                i_slot  = m_slot;
                i_nib   = m_lo[m_slot] ? byte_v[3:0] : byte_v[7:4];
                i_valid = m_play[m_slot];
                i_clr   = m_first[m_slot];
                if (m_play[m_slot]) begin
                    m_first[m_slot] = 0;
                    if (m_lo[m_slot]) begin
                        if (m_cnt[m_slot] == {m_end[m_slot], 4'hf}) begin
                            m_play[m_slot]  = 0;
                            m_flags[m_slot] = 1'b1;
                        end
                        m_cnt[m_slot] = m_cnt[m_slot] + 1'b1;
                    end
                    m_lo[m_slot] = !m_lo[m_slot];
                end
                if (m_slot == 5) begin
                    for (int ch = 0; ch < 6; ch++) begin
                        if (m_pend && m_mask[ch] && !m_off) begin
                            m_cnt[ch]   = {m_start[ch], 4'h0};
                            m_lo[ch]    = 0;
                            m_first[ch] = 1;
                            m_play[ch]  = 1;
                            m_flags[ch] = 1'b0;
                        end else if (m_pend && m_mask[ch]) begin
                            m_play[ch] = 0;
                        end
                    end
                    m_pend = 0;
                end
                m_slot = (m_slot == 5) ? 0 : m_slot + 1;
            end
            // Register writes land behind the slot work
            if (up_aon) begin
                m_pend = 1;
                m_off  = aon_cmd[7];
                m_mask = aon_cmd[5:0];
            end
            if (up_start) m_start[up_addr] = addr_in;
            if (up_end) m_end[up_addr] = addr_in;
            if (up_lracl < 6) begin
                m_pan[up_lracl] = lracl_in[7:6];
                m_lvl[up_lracl] = lracl_in[4:0];
            end
            if (done) begin
                exp_q.push_back(round_result(sum_l, sum_r, m_flags));
                sum_l = 0;
                sum_r = 0;
            end
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(string what, int expv, int actv);
        abort_run($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
                            test_name, what, expv, actv));
    endtask

    // ROM port every clock, each round at the falling edge
    initial begin
        logic [37:0] exp_v;
        int          idle;
        idle = 0;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1) begin
                assert (roe_n == !m_play[m_slot])
                    else report_mismatch("roe_n", !m_play[m_slot], roe_n);
                if (m_play[m_slot]) begin  // Address only matters while reading
                    assert (rom_addr == m_cnt[m_slot])
                        else report_mismatch("rom_addr", m_cnt[m_slot], rom_addr);
                end
            end
            if (mix_valid) begin
                idle = 0;
                assert (exp_q.size() > 0)
                    else abort_run("mix_valid pulsed with no round expected by the model");
                exp_v = exp_q.pop_front();
                assert (pcm_l == exp_v[31:16])
                    else report_mismatch("pcm_l", $signed(exp_v[31:16]), pcm_l);
                assert (pcm_r == exp_v[15:0])
                    else report_mismatch("pcm_r", $signed(exp_v[15:0]), pcm_r);
                assert (flags == exp_v[37:32])
                    else report_mismatch("flags", exp_v[37:32], flags);
                rounds_seen++;
            end else if (rst_n) begin
                idle++;
                assert (idle < 100) else abort_run("no mix_valid pulse within 100 clocks");
            end
        end
    end

    task automatic at_edge();
        @(posedge clk);
        #2;
    endtask

    // Random cen spacing of 1 to 3 clocks
    task automatic drive_cen();
        int gap;
        forever begin
            gap = $urandom_range(2, 0);
            #2 cen = 1'b1;
            @(posedge clk);
            if (gap > 0) begin
                #2 cen = 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
    endtask

    task automatic write_addr(int ch, logic [15:0] start_v, logic [15:0] end_v);
        at_edge();
        up_addr  = 3'(ch);
        addr_in  = start_v;
        up_start = 1'b1;
        at_edge();
        up_start = 1'b0;
        addr_in  = end_v;
        up_end   = 1'b1;
        at_edge();
        up_end   = 1'b0;
    endtask

    task automatic key_cmd(logic [7:0] cmd);
        at_edge();
        aon_cmd = cmd;
        up_aon  = 1'b1;
        at_edge();
        up_aon  = 1'b0;
    endtask

    task automatic set_pan(int ch, logic [7:0] val);
        at_edge();
        up_lracl = 3'(ch);
        lracl_in = val;
        at_edge();
        up_lracl = 3'd7;
    endtask

    task automatic clear_flag(logic [5:0] mask);
        at_edge();
        clr_flags = mask;
        at_edge();
        clr_flags = '0;
    endtask

    task automatic wait_rounds(int n);
        int target;
        target = rounds_seen + n;
        for (int t = 0; rounds_seen < target; t++) begin
            assert (t < n * 40 + 40)
                else abort_run($sformatf("%s stalled waiting for %0d rounds", test_name, n));
            at_edge();
        end
    endtask

    initial begin
        cen       = 1'b0;
        up_start  = 1'b0;
        up_end    = 1'b0;
        up_addr   = '0;
        addr_in   = '0;
        up_aon    = 1'b0;
        aon_cmd   = '0;
        up_lracl  = 3'd7;
        lracl_in  = '0;
        atl       = '0;
        clr_flags = '0;
        test_name = "reset";
        rounds_seen = 0;
        sat_rounds  = 0;
        clear_model();
        void'($urandom(32'h817d778d));
        for (int a = 0; a < (1 << 20); a++) rom[a] = 8'($urandom);
        for (int t = 0; rst_n !== 1'b1; t++) begin  // X before the generator starts
            assert (t < 10) else abort_run("reset never released");
            @(posedge clk);
        end
        fork
            drive_cen();
        join_none

        test_name = "single_channel";
        atl = 6'd63;
        write_addr(0, 16'h0010, 16'h0020);
        set_pan(0, 8'hdf);  // Both sides, full level
        key_cmd(8'h01);
        wait_rounds(40);

        test_name = "end_stop";  // 16 bytes, 32 rounds
        write_addr(1, 16'h0030, 16'h0030);
        set_pan(1, 8'hdf);
        key_cmd(8'h02);
        wait_rounds(40);
        assert (flags[1]) else abort_run("channel 1 flag did not set at its end address");
        clear_flag(6'b000010);
        wait_rounds(2);
        assert (!flags[1]) else abort_run("channel 1 flag did not clear");

        test_name = "key_off";
        write_addr(2, 16'h0100, 16'h0180);
        write_addr(3, 16'h0200, 16'h0280);
        set_pan(2, 8'hdf);
        set_pan(3, 8'hdf);
        key_cmd(8'h0c);
        wait_rounds(10);
        key_cmd(8'h81);  // Channel 0 off, 2 and 3 run on
        wait_rounds(20);

        test_name = "pan_level";
        set_pan(2, 8'h94);  // Left only, level 20
        set_pan(3, 8'h4a);  // Right only, level 10
        atl = 6'd40;
        wait_rounds(15);
        atl = 6'd20;
        wait_rounds(15);
        atl = 6'd63;

        test_name = "all_channels";
        for (int ch = 0; ch < 6; ch++) begin
            write_addr(ch, 16'h0400 + 16'(ch * 256), 16'h04ff + 16'(ch * 256));
            set_pan(ch, 8'hdf);
        end
        sat_rounds = 0;
        key_cmd(8'h3f);
        wait_rounds(80);
        assert (sat_rounds > 0) else abort_run("six full-level channels never saturated a round");

        test_name = "rekey";  // Channel 0 restarts mid-sample
        key_cmd(8'h01);
        wait_rounds(30);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
